/* Bender.yml */
package:
  name: riscv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/pipe_reg.sv
      - hdl/instr_decoder.sv
      - hdl/reg_file.sv
      - hdl/execute_unit.sv
      - hdl/riscv_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/clk_gen.sv
      - bench/riscv_core_sva.sv
      - bench/riscv_core_tb.sv

/* bench/clk_gen.sv */
`timescale 1ns/100ps

// free running clock, 4 ns period
module clk_gen #(
    parameter real half_period = 2.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(half_period) clk_o = ~clk_o;

endmodule

/* bench/riscv_core_sva.sv */
`timescale 1ns/100ps
`include "core_config.svh"

module riscv_core_sva (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic [`CORE_XLEN-1:0] rom_addr_i,
    input logic                  ram_we_i,
    input logic                  redirect_i
);

    int fail_count = 0;

    // write strobe always a clean level
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !$isunknown(ram_we_i))
        else begin
            $error("ram write strobe is unknown");
            fail_count++;
        end

    // first cycle out of reset holds a bubble
    assert property (@(posedge clk_i) $rose(rst_n_i) |-> !ram_we_i)
        else begin
            $error("ram write strobe high right after reset");
            fail_count++;
        end

    // sequential fetch out of reset without a redirect
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rst_n_i && !redirect_i |=> (rom_addr_i == $past(rom_addr_i) + 32'd4))
        else begin
            $error("fetch address did not step by four");
            fail_count++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) rom_addr_i[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            fail_count++;
        end

endmodule

bind riscv_core riscv_core_sva u_sva (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .rom_addr_i(rom_addr_o),
    .ram_we_i(ram_we_o), .redirect_i(ex_redirect)
);

/* bench/riscv_core_tb.sv */
`timescale 1ns/100ps
`include "core_config.svh"

module riscv_core_tb import core_pkg::*; ();

    localparam logic [31:0] fall_mark  = 32'h0000_00f1;
    localparam logic [31:0] taken_mark = 32'h0000_07a2;
    localparam logic [11:0] done_addr  = 12'h3fc;

    logic                  clk;
    logic                  rst_n;
    logic [`CORE_XLEN-1:0] rom_addr, rom_rdata;
    logic [`CORE_XLEN-1:0] ram_addr, ram_wdata, ram_rdata;
    logic                  ram_we;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] st_val [0:255];
    int          st_cnt [0:255];
    int          st_total;
    logic [31:0] exp_val [0:63];
    int          n_exp;
    int          pc_idx;
    int          errors;
    int          tests_run;
    int          tests_failed;

    clk_gen u_clk (.clk_o(clk));

    riscv_core uut (
        .clk_i(clk), .rst_n_i(rst_n),
        .rom_addr_o(rom_addr), .rom_rdata_i(rom_rdata),
        .ram_addr_o(ram_addr), .ram_we_o(ram_we),
        .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata)
    );

    ////////////////////////////////////////
    // memory models
    ////////////////////////////////////////
    assign rom_rdata = rom[rom_addr[9:2]];
    assign ram_rdata = ram[ram_addr[9:2]];

    // word write plus a log of every store
    always @(posedge clk) begin
        if (ram_we) begin
            ram[ram_addr[9:2]]    <= ram_wdata;
            st_val[ram_addr[9:2]] <= ram_wdata;
            st_cnt[ram_addr[9:2]] <= st_cnt[ram_addr[9:2]] + 1;
            st_total              <= st_total + 1;
        end
    end

    ////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // rv32i arithmetic rules
    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return 32'($signed(a) < $signed(b));
            ALU_SLTU: return 32'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return b;
        endcase
    endfunction

    function automatic logic [11:0] slot_off(input int s);
        return 12'(12'h200 + 4 * s);
    endfunction

    function automatic logic [31:0] cur_pc();
        return 32'(pc_idx * 4);
    endfunction

    ////////////////////////////////////////
    // program building
    ////////////////////////////////////////
    task automatic emit(input logic [31:0] word);
        rom[pc_idx] = word;
        pc_idx++;
    endtask

    task automatic store_result(input logic [4:0] rs2, input logic [31:0] expected);
        emit(enc_s(slot_off(n_exp), rs2, 5'd0));
        exp_val[n_exp] = expected;
        n_exp++;
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            rom[i]    = `CORE_NOP;
            ram[i]    = 32'hbad0_0000 | i;
            st_cnt[i] = 0;
        end
        st_total = 0;
        pc_idx   = 0;
        n_exp    = 0;
    endtask

    // done store, then a self loop
    task automatic finish_program();
        emit(enc_s(done_addr, 5'd0, 5'd0));
        emit(enc_j(21'd0, 5'd0));
    endtask

    ////////////////////////////////////////
    // reset, waits and checks
    ////////////////////////////////////////
    task automatic hold_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
    endtask

    task automatic release_reset();
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic check_word(input string what, input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: fetch address %s is %h, expected %h",
                     $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic wait_store(input logic [11:0] addr);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < 1000 && !seen; c++) begin
            @(negedge clk);
            if (st_cnt[addr[9:2]] > 0) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("timeout: the core never stored to address %h", addr);
            errors++;
        end
    endtask

    task automatic run_program();
        finish_program();
        release_reset();
        wait_store(done_addr);
        for (int i = 0; i < n_exp; i++) begin
            check_word($sformatf("store count of slot %0d", i), st_cnt[128 + i], 1);
            check_word($sformatf("value of slot %0d", i), st_val[128 + i], exp_val[i]);
        end
        check_word("total store count", st_total, n_exp + 1);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_reset();
        int err0;
        err0 = errors;
        hold_reset();
        clear_program();
        release_reset();
        @(negedge clk);
        check_addr("after reset", rom_addr, `CORE_RESET_PC);
        check_word("ram write strobe after reset", 32'(ram_we), 32'd0);
        end_test("reset", err0);
    endtask

    task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3, input alu_op_e op,
                         input logic [31:0] a, input logic [31:0] b);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        store_result(5'd3, ref_alu(op, a, b));
    endtask

    task automatic alu_i(input logic [11:0] imm, input logic [2:0] f3, input alu_op_e op,
                         input logic [31:0] a);
        emit(enc_i(imm, 5'd1, f3, 5'd3, OP_IMM));
        store_result(5'd3, ref_alu(op, a, {{20{imm[11]}}, imm}));
    endtask

    task automatic test_alu();
        int          err0;
        logic [31:0] a, b, pc;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] u;
        err0 = errors;
        a    = $urandom;
        b    = $urandom;
        imm  = 12'($urandom);
        sh   = 5'($urandom);
        u    = 20'($urandom);
        hold_reset();
        clear_program();
        ram[0] = a;
        ram[1] = b;
        emit(enc_i(12'd0, 5'd0, 3'b010, 5'd1, OP_LOAD));
        emit(enc_i(12'd4, 5'd0, 3'b010, 5'd2, OP_LOAD));
        alu_r(7'h00, 3'b000, ALU_ADD, a, b);
        alu_r(7'h20, 3'b000, ALU_SUB, a, b);
        alu_r(7'h00, 3'b001, ALU_SLL, a, b);
        alu_r(7'h00, 3'b010, ALU_SLT, a, b);
        alu_r(7'h00, 3'b011, ALU_SLTU, a, b);
        alu_r(7'h00, 3'b100, ALU_XOR, a, b);
        alu_r(7'h00, 3'b101, ALU_SRL, a, b);
        alu_r(7'h20, 3'b101, ALU_SRA, a, b);
        alu_r(7'h00, 3'b110, ALU_OR, a, b);
        alu_r(7'h00, 3'b111, ALU_AND, a, b);
        alu_i(imm, 3'b000, ALU_ADD, a);
        alu_i(imm, 3'b010, ALU_SLT, a);
        alu_i(imm, 3'b011, ALU_SLTU, a);
        alu_i(imm, 3'b100, ALU_XOR, a);
        alu_i(imm, 3'b110, ALU_OR, a);
        alu_i(imm, 3'b111, ALU_AND, a);
        alu_i({7'h00, sh}, 3'b001, ALU_SLL, a);
        alu_i({7'h00, sh}, 3'b101, ALU_SRL, a);
        alu_i({7'h20, sh}, 3'b101, ALU_SRA, a);
        emit(enc_u(u, 5'd3, OP_LUI));
        store_result(5'd3, {u, 12'b0});
        pc = cur_pc();
        emit(enc_u(u, 5'd3, OP_AUIPC));
        store_result(5'd3, pc + {u, 12'b0});
        run_program();
        end_test("alu", err0);
    endtask

    task automatic test_forwarding();
        int          err0;
        logic [31:0] a, c;
        err0 = errors;
        a    = $urandom;
        c    = $urandom;
        hold_reset();
        clear_program();
        ram[0] = a;
        ram[1] = 32'h0000_0008;
        ram[2] = c;
        // load, then its users back to back
        emit(enc_i(12'd0, 5'd0, 3'b010, 5'd1, OP_LOAD));
        emit(enc_i(12'd5, 5'd1, 3'b000, 5'd2, OP_IMM));
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        emit(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
        emit(enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5));
        store_result(5'd5, a ^ (2 * a + 5));
        store_result(5'd2, a + 5);
        store_result(5'd3, 2 * a + 5);
        store_result(5'd4, a);
        emit(enc_i(12'd0, 5'd0, 3'b010, 5'd6, OP_LOAD));
        store_result(5'd6, a);
        // pointer chase through a loaded address
        emit(enc_i(12'd4, 5'd0, 3'b010, 5'd7, OP_LOAD));
        emit(enc_i(12'd0, 5'd7, 3'b010, 5'd8, OP_LOAD));
        store_result(5'd8, c);
        emit(enc_i(12'd7, 5'd0, 3'b000, 5'd0, OP_IMM));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
        store_result(5'd9, 32'd0);
        run_program();
        end_test("forwarding", err0);
    endtask

    task automatic test_loads();
        int          err0;
        logic [31:0] w;
        logic [11:0] off;
        err0 = errors;
        hold_reset();
        clear_program();
        for (int k = 0; k < 2; k++) begin
            // top bits of byte and half set, then clear
            w      = (k == 0) ? ($urandom | 32'h8000_8080) : ($urandom & 32'h7fff_7f7f);
            off    = 12'(4 * k);
            ram[k] = w;
            emit(enc_i(off, 5'd0, LK_BYTE, 5'd1, OP_LOAD));
            store_result(5'd1, {{24{w[7]}}, w[7:0]});
            emit(enc_i(off, 5'd0, LK_HALF, 5'd1, OP_LOAD));
            store_result(5'd1, {{16{w[15]}}, w[15:0]});
            emit(enc_i(off, 5'd0, LK_BYTE_U, 5'd1, OP_LOAD));
            store_result(5'd1, {24'b0, w[7:0]});
            emit(enc_i(off, 5'd0, LK_HALF_U, 5'd1, OP_LOAD));
            store_result(5'd1, {16'b0, w[15:0]});
            emit(enc_i(off, 5'd0, LK_WORD, 5'd1, OP_LOAD));
            store_result(5'd1, w);
        end
        run_program();
        end_test("loads", err0);
    endtask

    // fall-through and taken paths store different markers to one slot
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input bit taken);
        int s;
        s          = n_exp;
        exp_val[s] = taken ? taken_mark : fall_mark;
        n_exp++;
        emit(enc_b(13'd12, rs2, rs1, f3));
        emit(enc_s(slot_off(s), 5'd10, 5'd0));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_s(slot_off(s), 5'd11, 5'd0));
    endtask

    task automatic test_control();
        int          err0;
        int          s;
        logic [31:0] q;
        err0 = errors;
        hold_reset();
        clear_program();
        emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd3, OP_IMM));
        emit(enc_i(fall_mark[11:0], 5'd0, 3'b000, 5'd10, OP_IMM));
        emit(enc_i(taken_mark[11:0], 5'd0, 3'b000, 5'd11, OP_IMM));
        // x1 = -3, x2 = x3 = 5
        branch_case(3'b000, 5'd2, 5'd3, 1'b1);
        branch_case(3'b000, 5'd1, 5'd2, 1'b0);
        branch_case(3'b001, 5'd1, 5'd2, 1'b1);
        branch_case(3'b001, 5'd2, 5'd3, 1'b0);
        branch_case(3'b100, 5'd1, 5'd2, 1'b1);
        branch_case(3'b100, 5'd2, 5'd1, 1'b0);
        branch_case(3'b101, 5'd2, 5'd1, 1'b1);
        branch_case(3'b101, 5'd2, 5'd3, 1'b1);
        branch_case(3'b101, 5'd1, 5'd2, 1'b0);
        branch_case(3'b110, 5'd2, 5'd1, 1'b1);
        branch_case(3'b110, 5'd1, 5'd2, 1'b0);
        branch_case(3'b111, 5'd1, 5'd2, 1'b1);
        branch_case(3'b111, 5'd2, 5'd1, 1'b0);
        // jal over two stores, link in x5
        q          = cur_pc();
        s          = n_exp;
        exp_val[s] = taken_mark;
        n_exp++;
        emit(enc_j(21'd12, 5'd5));
        emit(enc_s(slot_off(s), 5'd10, 5'd0));
        emit(enc_s(slot_off(s), 5'd10, 5'd0));
        emit(enc_s(slot_off(s), 5'd11, 5'd0));
        store_result(5'd5, q + 32'd4);
        // jalr with an odd target, bit 0 dropped
        q          = cur_pc();
        s          = n_exp;
        exp_val[s] = taken_mark;
        n_exp++;
        emit(enc_i(12'(q + 17), 5'd0, 3'b000, 5'd6, OP_IMM));
        emit(enc_i(12'd0, 5'd6, 3'b000, 5'd7, OP_JALR));
        emit(enc_s(slot_off(s), 5'd10, 5'd0));
        emit(enc_s(slot_off(s), 5'd10, 5'd0));
        emit(enc_s(slot_off(s), 5'd11, 5'd0));
        store_result(5'd7, q + 32'd8);
        run_program();
        end_test("control", err0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(75));
        rst_n        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_program();
        test_reset();
        test_alu();
        test_forwarding();
        test_loads();
        test_control();
        $display("summary: %0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, uut.u_sva.fail_count);
        if (errors == 0 && uut.u_sva.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* hdl/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and address width
`define CORE_XLEN 32

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// architectural integer registers
`define CORE_REG_COUNT 32

// addi x0,x0,0 used as pipeline bubble
`define CORE_NOP 32'h0000_0013

`endif

/* hdl/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // encoded exactly as the load funct3 field
    typedef enum logic [2:0] {
        LK_BYTE   = 3'b000,
        LK_HALF   = 3'b001,
        LK_WORD   = 3'b010,
        LK_BYTE_U = 3'b100,
        LK_HALF_U = 3'b101
    } load_kind_e;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] instr;
        logic [`CORE_XLEN-1:0] pc;
    } fx_payload_t;

    typedef struct packed {
        logic                  reg_we;
        logic [4:0]            rd;
        logic                  is_load;
        load_kind_e            load_kind;
        logic [`CORE_XLEN-1:0] result;
        logic [`CORE_XLEN-1:0] ram_rdata;
    } xw_payload_t;

endpackage

/* hdl/execute_unit.sv */
`timescale 1ns/100ps
`include "core_config.svh"

module execute_unit import core_pkg::*; (
    input  logic [`CORE_XLEN-1:0] pc_i,
    input  logic [4:0]            rs1_i,
    input  logic [4:0]            rs2_i,
    input  logic [`CORE_XLEN-1:0] rs1_data_i,
    input  logic [`CORE_XLEN-1:0] rs2_data_i,
    input  logic [`CORE_XLEN-1:0] imm_i,
    input  alu_op_e               alu_op_i,
    input  logic                  use_imm_i,
    input  logic                  use_pc_i,
    input  logic                  is_branch_i,
    input  logic                  is_jal_i,
    input  logic                  is_jalr_i,
    input  logic [2:0]            funct3_i,
    input  logic                  wb_we_i,
    input  logic [4:0]            wb_rd_i,
    input  logic [`CORE_XLEN-1:0] wb_data_i,
    output logic [`CORE_XLEN-1:0] result_o,
    output logic [`CORE_XLEN-1:0] store_data_o,
    output logic                  redirect_o,
    output logic [`CORE_XLEN-1:0] target_o
);

    logic [`CORE_XLEN-1:0] rs1_fwd;
    logic [`CORE_XLEN-1:0] rs2_fwd;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [`CORE_XLEN-1:0] jalr_sum;
    logic                  taken;

    ////////////////////////////////////////
    // forwarding from W
    ////////////////////////////////////////
    assign rs1_fwd = (wb_we_i && wb_rd_i != 5'd0 && wb_rd_i == rs1_i) ? wb_data_i : rs1_data_i;
    assign rs2_fwd = (wb_we_i && wb_rd_i != 5'd0 && wb_rd_i == rs2_i) ? wb_data_i : rs2_data_i;

    assign op_a = use_pc_i  ? pc_i  : rs1_fwd;
    assign op_b = use_imm_i ? imm_i : rs2_fwd;

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////
    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // link address for jumps
    assign result_o     = (is_jal_i || is_jalr_i) ? pc_i + 32'd4 : alu_res;
    assign store_data_o = rs2_fwd;

    ////////////////////////////////////////
    // branch decision and target
    ////////////////////////////////////////
    always_comb begin
        case (funct3_i)
            3'b000:  taken = (rs1_fwd == rs2_fwd);
            3'b001:  taken = (rs1_fwd != rs2_fwd);
            3'b100:  taken = ($signed(rs1_fwd) < $signed(rs2_fwd));
            3'b101:  taken = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            3'b110:  taken = (rs1_fwd < rs2_fwd);
            3'b111:  taken = (rs1_fwd >= rs2_fwd);
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum   = rs1_fwd + imm_i;
    assign target_o   = is_jalr_i ? {jalr_sum[`CORE_XLEN-1:1], 1'b0} : pc_i + imm_i;
    assign redirect_o = is_jal_i || is_jalr_i || (is_branch_i && taken);

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/100ps
`include "core_config.svh"

module instr_decoder import core_pkg::*; (
    input  logic [`CORE_XLEN-1:0] instr_i,
    output logic [4:0]            rs1_o,
    output logic [4:0]            rs2_o,
    output logic [4:0]            rd_o,
    output logic [`CORE_XLEN-1:0] imm_o,
    output alu_op_e               alu_op_o,
    output logic                  use_imm_o,
    output logic                  use_pc_o,
    output logic                  is_branch_o,
    output logic                  is_jal_o,
    output logic                  is_jalr_o,
    output logic                  is_load_o,
    output logic                  is_store_o,
    output logic                  reg_write_o,
    output logic [2:0]            funct3_o,
    output load_kind_e            load_kind_o
);

    logic [`CORE_XLEN-1:0] imm_i_type;
    logic [`CORE_XLEN-1:0] imm_s_type;
    logic [`CORE_XLEN-1:0] imm_b_type;
    logic [`CORE_XLEN-1:0] imm_u_type;
    logic [`CORE_XLEN-1:0] imm_j_type;

    // funct3 to alu op, alt selects sub / sra
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign rd_o     = instr_i[11:7];
    assign funct3_o = instr_i[14:12];

    ////////////////////////////////////////
    // immediate formats
    ////////////////////////////////////////
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    ////////////////////////////////////////
    // control levels
    ////////////////////////////////////////
    always_comb begin
        imm_o       = '0;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        use_pc_o    = 1'b0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        reg_write_o = 1'b0;
        load_kind_o = LK_WORD;
        case (instr_i[6:0])
            OP_LUI: begin
                imm_o       = imm_u_type;
                alu_op_o    = ALU_PASS_B;
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            OP_AUIPC: begin
                imm_o       = imm_u_type;
                use_imm_o   = 1'b1;
                use_pc_o    = 1'b1;
                reg_write_o = 1'b1;
            end
            OP_IMM: begin
                imm_o       = imm_i_type;
                // only the shift-right form has an alternate encoding here
                alu_op_o    = alu_from_funct3(instr_i[14:12],
                                              (instr_i[14:12] == 3'b101) && instr_i[30]);
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            OP_REG: begin
                alu_op_o    = alu_from_funct3(instr_i[14:12], instr_i[30]);
                reg_write_o = 1'b1;
            end
            OP_LOAD: begin
                imm_o       = imm_i_type;
                use_imm_o   = 1'b1;
                is_load_o   = 1'b1;
                reg_write_o = 1'b1;
                load_kind_o = load_kind_e'(instr_i[14:12]);
            end
            OP_STORE: begin
                imm_o      = imm_s_type;
                use_imm_o  = 1'b1;
                is_store_o = 1'b1;
            end
            OP_BRANCH: begin
                imm_o       = imm_b_type;
                is_branch_o = 1'b1;
            end
            OP_JAL: begin
                imm_o       = imm_j_type;
                is_jal_o    = 1'b1;
                reg_write_o = 1'b1;
            end
            OP_JALR: begin
                imm_o       = imm_i_type;
                is_jalr_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            // fence, system and anything unknown fall through as nop
            default: ;
        endcase
    end

endmodule

/* hdl/pipe_reg.sv */
`timescale 1ns/100ps

// generic stage register, bubble on reset or flush
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  T     bubble_i,
    input  T     d_i,
    output T     q_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            q_o <= bubble_i;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/100ps
`include "core_config.svh"

module reg_file (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [4:0]            rs1_addr_i,
    input  logic [4:0]            rs2_addr_i,
    output logic [`CORE_XLEN-1:0] rs1_data_o,
    output logic [`CORE_XLEN-1:0] rs2_data_o,
    input  logic                  we_i,
    input  logic [4:0]            rd_addr_i,
    input  logic [`CORE_XLEN-1:0] rd_data_i
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_REG_COUNT];

    // x0 never written, so it stays at its reset zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != 5'd0)) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

/* hdl/riscv_core.sv */
`timescale 1ns/100ps
`include "core_config.svh"

module riscv_core import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    output logic [`CORE_XLEN-1:0] rom_addr_o,
    input  logic [`CORE_XLEN-1:0] rom_rdata_i,
    output logic [`CORE_XLEN-1:0] ram_addr_o,
    output logic                  ram_we_o,
    output logic [`CORE_XLEN-1:0] ram_wdata_o,
    input  logic [`CORE_XLEN-1:0] ram_rdata_i
);

    logic [`CORE_XLEN-1:0] pc_q;
    fx_payload_t           fx_d, fx_q, fx_bubble;
    xw_payload_t           xw_d, xw_q, xw_bubble;

    // X stage decode results
    logic [4:0]            dec_rs1, dec_rs2, dec_rd;
    logic [`CORE_XLEN-1:0] dec_imm;
    alu_op_e               dec_alu_op;
    logic                  dec_use_imm, dec_use_pc;
    logic                  dec_branch, dec_jal, dec_jalr;
    logic                  dec_load, dec_store, dec_reg_write;
    logic [2:0]            dec_funct3;
    load_kind_e            dec_load_kind;
    logic [`CORE_XLEN-1:0] rs1_data, rs2_data;
    logic [`CORE_XLEN-1:0] ex_result, ex_store_data, ex_target;
    logic                  ex_redirect;

    // W stage
    logic [`CORE_XLEN-1:0] load_ext;
    logic [`CORE_XLEN-1:0] wb_data;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `CORE_RESET_PC;
        end else begin
            pc_q <= ex_redirect ? ex_target : pc_q + 32'd4;
        end
    end

    assign rom_addr_o = pc_q;
    assign fx_d       = '{instr: rom_rdata_i, pc: pc_q};
    assign fx_bubble  = '{instr: `CORE_NOP, pc: `CORE_RESET_PC};

    // slot behind a taken transfer is squashed
    pipe_reg #(.T(fx_payload_t)) u_fx_reg (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(ex_redirect),
        .bubble_i(fx_bubble), .d_i(fx_d), .q_o(fx_q)
    );

    ////////////////////////////////////////
    // execute
    ////////////////////////////////////////
    instr_decoder u_decoder (
        .instr_i(fx_q.instr), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
        .imm_o(dec_imm), .alu_op_o(dec_alu_op), .use_imm_o(dec_use_imm),
        .use_pc_o(dec_use_pc), .is_branch_o(dec_branch), .is_jal_o(dec_jal),
        .is_jalr_o(dec_jalr), .is_load_o(dec_load), .is_store_o(dec_store),
        .reg_write_o(dec_reg_write), .funct3_o(dec_funct3), .load_kind_o(dec_load_kind)
    );

    reg_file u_reg_file (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .rs1_addr_i(dec_rs1), .rs2_addr_i(dec_rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(xw_q.reg_we), .rd_addr_i(xw_q.rd), .rd_data_i(wb_data)
    );

    execute_unit u_execute (
        .pc_i(fx_q.pc), .rs1_i(dec_rs1), .rs2_i(dec_rs2),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(dec_imm),
        .alu_op_i(dec_alu_op), .use_imm_i(dec_use_imm), .use_pc_i(dec_use_pc),
        .is_branch_i(dec_branch), .is_jal_i(dec_jal), .is_jalr_i(dec_jalr),
        .funct3_i(dec_funct3), .wb_we_i(xw_q.reg_we), .wb_rd_i(xw_q.rd),
        .wb_data_i(wb_data), .result_o(ex_result), .store_data_o(ex_store_data),
        .redirect_o(ex_redirect), .target_o(ex_target)
    );

    // data ram, word stores only
    assign ram_addr_o  = ex_result;
    assign ram_we_o    = dec_store;
    assign ram_wdata_o = ex_store_data;

    assign xw_d = '{reg_we: dec_reg_write, rd: dec_rd, is_load: dec_load,
                    load_kind: dec_load_kind, result: ex_result,
                    ram_rdata: dec_load ? ram_rdata_i : '0};
    assign xw_bubble = '{reg_we: 1'b0, rd: 5'd0, is_load: 1'b0, load_kind: LK_WORD,
                         result: '0, ram_rdata: '0};

    pipe_reg #(.T(xw_payload_t)) u_xw_reg (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(1'b0),
        .bubble_i(xw_bubble), .d_i(xw_d), .q_o(xw_q)
    );

    ////////////////////////////////////////
    // writeback
    ////////////////////////////////////////
    // byte and half always come from lane zero
    always_comb begin
        case (xw_q.load_kind)
            LK_BYTE:   load_ext = {{24{xw_q.ram_rdata[7]}}, xw_q.ram_rdata[7:0]};
            LK_HALF:   load_ext = {{16{xw_q.ram_rdata[15]}}, xw_q.ram_rdata[15:0]};
            LK_BYTE_U: load_ext = {24'b0, xw_q.ram_rdata[7:0]};
            LK_HALF_U: load_ext = {16'b0, xw_q.ram_rdata[15:0]};
            default:   load_ext = xw_q.ram_rdata;
        endcase
    end

    assign wb_data = xw_q.is_load ? load_ext : xw_q.result;

endmodule

/* project.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/pipe_reg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/riscv_core.sv
bench/clk_gen.sv
bench/riscv_core_sva.sv
bench/riscv_core_tb.sv
